/* sim.f */
src/lane_pkg.sv
src/vector_regfile.sv
src/element_extract.sv
src/op_ctrl_pipe.sv
src/execute_stage.sv
src/writeback_stage.sv
src/vector_lane.sv
verification/vector_lane_sva.sv
verification/tb_vector_lane.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the lane testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_vector_lane -o tb_vector_lane \
    > build.log 2>&1 \
    && ./obj_dir/tb_vector_lane > sim.log 2>&1 \
    || { cat build.log; echo "SOME TESTS FAILED" >> sim.log; }

cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0

/* verification/tb_vector_lane.sv */
module tb_vector_lane;
    import lane_pkg::*;

    logic     clk_i;
    logic     rst_i;
    logic     op_valid_i;
    logic     load_i;
    vaddr_t   raddr_a_i;
    vaddr_t   raddr_b_i;
    el_idx_t  el_idx_a_i;
    el_idx_t  el_idx_b_i;
    sew_t     sew_i;
    alu_op_t  alu_op_i;
    op2_src_t op2_src_i;
    word_t    scalar_i;
    imm_t     imm_i;
    vaddr_t   waddr_i;
    bwen_t    bwen_i;
    word_t    load_data_i;
    logic     vm_i;
    maddr_t   mask_idx_i;
    logic     mask_we_i;
    word_t    result_o;
    logic     result_valid_o;

    // Reference state plus writes that have not landed yet
    word_t                 model_vrf [VRF_DEPTH];
    logic [MASK_DEPTH-1:0] model_mask;
    int                    pend_edge [$];
    vaddr_t                pend_addr [$];
    bwen_t                 pend_bwen [$];
    word_t                 pend_data [$];
    logic                  pend_vm   [$];
    maddr_t                pend_midx [$];
    logic                  pend_mwe  [$];

    // Results in flight
    word_t exp_data [$];
    int    exp_edge [$];
    string exp_name [$];

    integer seed     = 32'hc4f1_390c;
    int     edge_cnt = 0;
    int     checks   = 0;
    int     errors   = 0;

    vector_lane DUT (.*);

    initial clk_i = 1'b0;
    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        edge_cnt <= edge_cnt + 1;
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    function automatic word_t element_of(word_t w, el_idx_t idx, sew_t sew);
        if (sew == SEW_8) begin
            return (w >> (8 * idx)) & 32'h0000_00ff;
        end
        if (sew == SEW_16) begin
            return (w >> (16 * idx[0])) & 32'h0000_ffff;
        end
        return (sew == SEW_32) ? w : 32'd0;
    endfunction

    function automatic word_t alu_model(alu_op_t op, word_t a, word_t b);
        case (op)
            OP_ADD:   return a + b;
            OP_SUB:   return a - b;
            OP_AND:   return a & b;
            OP_OR:    return a | b;
            OP_XOR:   return a ^ b;
            OP_SLL:   return a << b[4:0];
            OP_SRL:   return a >> b[4:0];
            OP_MSEQ:  return (a == b) ? 32'd1 : 32'd0;
            OP_MSLTU: return (a < b) ? 32'd1 : 32'd0;
            default:  return 32'd0;
        endcase
    endfunction

    // Land every write whose edge comes before edge e
    task automatic apply_writes(input int e);
        bwen_t be;
        while (pend_edge.size() > 0 && pend_edge[0] < e) begin
            // Gate uses the mask bit stored before this edge
            be = (pend_vm[0] && !model_mask[pend_midx[0]]) ? 4'h0 : pend_bwen[0];
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    model_vrf[pend_addr[0]][8*b +: 8] = pend_data[0][8*b +: 8];
                end
            end
            if (pend_mwe[0]) begin
                model_mask[pend_midx[0]] = pend_data[0][0];
            end
            pend_edge.delete(0);
            pend_addr.delete(0);
            pend_bwen.delete(0);
            pend_data.delete(0);
            pend_vm.delete(0);
            pend_midx.delete(0);
            pend_mwe.delete(0);
        end
    endtask

    // Item on the inputs is sampled at the next rising edge
    task automatic record_issue(input string name);
        int    e;
        word_t op2;
        word_t res;
        e = edge_cnt + 1;
        apply_writes(e);
        if (op_valid_i || load_i) begin
            case (op2_src_i)
                OP2_VREG:   op2 = element_of(model_vrf[raddr_b_i], el_idx_b_i, sew_i);
                OP2_SCALAR: op2 = scalar_i;
                default:    op2 = {27'd0, imm_i};
            endcase
            res = alu_model(alu_op_i, element_of(model_vrf[raddr_a_i], el_idx_a_i, sew_i), op2);
            pend_edge.push_back(e + 3);
            pend_addr.push_back(waddr_i);
            pend_bwen.push_back(bwen_i);
            pend_data.push_back(load_i ? load_data_i : res);
            pend_vm.push_back(vm_i);
            pend_midx.push_back(mask_idx_i);
            pend_mwe.push_back(op_valid_i && mask_we_i);
            if (op_valid_i) begin
                exp_data.push_back(res);
                exp_edge.push_back(e + 2);
                exp_name.push_back(name);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    task automatic random_fields();
        op_valid_i  = 1'b0;
        load_i      = 1'b0;
        raddr_a_i   = vaddr_t'({$random(seed)} % 16);
        raddr_b_i   = vaddr_t'({$random(seed)} % 16);
        el_idx_a_i  = el_idx_t'($random(seed));
        el_idx_b_i  = el_idx_t'($random(seed));
        sew_i       = SEW_32;
        alu_op_i    = alu_op_t'({$random(seed)} % 9);
        op2_src_i   = op2_src_t'({$random(seed)} % 3);
        scalar_i    = $random(seed);
        imm_i       = imm_t'($random(seed));
        waddr_i     = vaddr_t'(32 + {$random(seed)} % 32);
        bwen_i      = 4'hf;
        load_data_i = $random(seed);
        vm_i        = 1'b0;
        mask_idx_i  = maddr_t'($random(seed));
        mask_we_i   = 1'b0;
    endtask

    task automatic begin_cycle();
        @(negedge clk_i);
        random_fields();
    endtask

    //////////////////////////////////////////////////
    // Result checks at the falling edge
    //////////////////////////////////////////////////
    always @(negedge clk_i) begin
        assert (rst_i || !result_valid_o) else begin
            $display("ERROR: result_valid_o high during reset");
            errors++;
        end
        if (rst_i && result_valid_o) begin
            assert (exp_data.size() > 0) else begin
                $display("ERROR: result_valid_o high with no operation outstanding");
                errors++;
            end
            if (exp_data.size() > 0) begin
                checks++;
                assert (result_o == exp_data[0] && edge_cnt == exp_edge[0]) else begin
                    $display("[FAIL] %s expected %h at edge %0d, actual %h at edge %0d",
                             exp_name[0], exp_data[0], exp_edge[0], result_o, edge_cnt);
                    errors++;
                end
                exp_data.delete(0);
                exp_edge.delete(0);
                exp_name.delete(0);
            end
        end
    end

    initial begin
        int waited;
        for (int i = 0; i < VRF_DEPTH; i++) begin
            model_vrf[i] = '0;
        end
        model_mask = '0;
        rst_i      = 1'b0;
        random_fields();
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b1;

        // Byte-enabled loads then whole-word read back
        for (int i = 0; i < 32; i++) begin
            begin_cycle();
            load_i  = 1'b1;
            waddr_i = vaddr_t'(i % 16);
            bwen_i  = bwen_t'($random(seed));
            record_issue("load_bytes");
        end
        for (int i = 0; i < 16; i++) begin
            begin_cycle();
            op_valid_i = 1'b1;
            raddr_a_i  = vaddr_t'(i);
            alu_op_i   = OP_OR;
            op2_src_i  = OP2_IMM;
            imm_i      = '0;
            record_issue("load_readback");
        end

        // Known words then byte, halfword and reserved widths
        for (int i = 0; i < 16; i++) begin
            begin_cycle();
            load_i  = 1'b1;
            waddr_i = vaddr_t'(i);
            record_issue("load_words");
        end
        for (int i = 0; i < 48; i++) begin
            begin_cycle();
            op_valid_i = 1'b1;
            sew_i      = sew_t'(i % 4);
            alu_op_i   = OP_OR;
            op2_src_i  = (i % 2 != 0) ? OP2_VREG : OP2_IMM;
            imm_i      = '0;
            record_issue("element_extract");
        end

        // Every operation with every operand source
        for (int op = 0; op < 9; op++) begin
            for (int k = 0; k < 9; k++) begin
                begin_cycle();
                op_valid_i = 1'b1;
                alu_op_i   = alu_op_t'(op);
                op2_src_i  = op2_src_t'(k % 3);
                record_issue("alu_ops");
            end
        end

        // Compares into the mask file, then masked writes and their read back
        for (int i = 0; i < 16; i++) begin
            begin_cycle();
            op_valid_i = 1'b1;
            alu_op_i   = (i % 2 != 0) ? OP_MSEQ : OP_MSLTU;
            op2_src_i  = OP2_VREG;
            raddr_b_i  = (i % 4 == 1) ? raddr_a_i : raddr_b_i;
            mask_idx_i = maddr_t'(i);
            mask_we_i  = 1'b1;
            record_issue("mask_compare");
        end
        for (int i = 0; i < 16; i++) begin
            begin_cycle();
            op_valid_i = 1'b1;
            alu_op_i   = OP_ADD;
            op2_src_i  = OP2_SCALAR;
            vm_i       = 1'b1;
            mask_idx_i = maddr_t'(i);
            waddr_i    = vaddr_t'(16 + i);
            record_issue("masked_write");
        end
        for (int i = 0; i < 16; i++) begin
            begin_cycle();
            op_valid_i = 1'b1;
            raddr_a_i  = vaddr_t'(16 + i);
            alu_op_i   = OP_OR;
            op2_src_i  = OP2_IMM;
            imm_i      = '0;
            record_issue("masked_readback");
        end

        // Back-to-back issue over four words with hazards every cycle
        for (int i = 0; i < 300; i++) begin
            begin_cycle();
            load_i     = ({$random(seed)} % 4 == 0);
            op_valid_i = !load_i;
            raddr_a_i  = vaddr_t'({$random(seed)} % 4);
            raddr_b_i  = vaddr_t'({$random(seed)} % 4);
            waddr_i    = vaddr_t'({$random(seed)} % 4);
            sew_i      = sew_t'($random(seed));
            bwen_i     = bwen_t'($random(seed));
            vm_i       = !load_i && ($random(seed) % 2 != 0);
            mask_idx_i = maddr_t'({$random(seed)} % 4);
            mask_we_i  = (alu_op_i == OP_MSEQ || alu_op_i == OP_MSLTU) && ($random(seed) % 2 != 0);
            record_issue("back_to_back");
        end

        waited = 0;
        while (exp_data.size() > 0 && waited < 50) begin
            begin_cycle();
            record_issue("idle");
            waited++;
        end
        if (exp_data.size() > 0) begin
            $display("ERROR: %0d results never arrived", exp_data.size());
            errors++;
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verification/vector_lane_sva.sv */
module vector_lane_sva (
    input logic clk_i,
    input logic rst_i,
    input logic op_valid_i,
    input logic load_i,
    input logic result_valid_o
);
    import lane_pkg::*;

    //////////////////////////////////////////////////
    // Top-level timing
    //////////////////////////////////////////////////
    a_result_latency: assert property (@(posedge clk_i) disable iff (!rst_i)
        result_valid_o == $past(op_valid_i, LANE_LATENCY))
        else $error("result_valid_o does not follow op_valid_i by the lane latency");

    // Loads and operations share the issue slot
    a_issue_exclusive: assert property (@(posedge clk_i) disable iff (!rst_i)
        !(op_valid_i && load_i))
        else $error("op_valid_i and load_i issued together");

    a_reset_valid: assert property (@(posedge clk_i) !rst_i |=> !result_valid_o)
        else $error("result_valid_o high after reset");

endmodule

bind vector_lane vector_lane_sva u_sva (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .op_valid_i     (op_valid_i),
    .load_i         (load_i),
    .result_valid_o (result_valid_o)
);

/* src/vector_lane.sv */
module vector_lane (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               op_valid_i,
    input  logic               load_i,
    input  lane_pkg::vaddr_t   raddr_a_i,
    input  lane_pkg::vaddr_t   raddr_b_i,
    input  lane_pkg::el_idx_t  el_idx_a_i,
    input  lane_pkg::el_idx_t  el_idx_b_i,
    input  lane_pkg::sew_t     sew_i,
    input  lane_pkg::alu_op_t  alu_op_i,
    input  lane_pkg::op2_src_t op2_src_i,
    input  lane_pkg::word_t    scalar_i,
    input  lane_pkg::imm_t     imm_i,
    input  lane_pkg::vaddr_t   waddr_i,
    input  lane_pkg::bwen_t    bwen_i,
    input  lane_pkg::word_t    load_data_i,
    input  logic               vm_i,
    input  lane_pkg::maddr_t   mask_idx_i,
    input  logic               mask_we_i,
    output lane_pkg::word_t    result_o,
    output logic               result_valid_o
);
    import lane_pkg::*;

    // Read and extract
    word_t    rdata_a;
    word_t    rdata_b;
    el_idx_t  ext_idx_a;
    el_idx_t  ext_idx_b;
    sew_t     ext_sew;
    word_t    opa;
    word_t    opb;

    // Delayed control at the execute stage
    logic     ex_valid;
    logic     ex_load;
    alu_op_t  ex_alu_op;
    op2_src_t ex_op2_src;
    word_t    ex_scalar;
    imm_t     ex_imm;
    vaddr_t   ex_waddr;
    bwen_t    ex_bwen;
    word_t    ex_load_data;
    logic     ex_vm;
    maddr_t   ex_mask_idx;
    logic     ex_mask_we;

    // Write-back
    logic     wb_we;
    word_t    wb_data;
    vaddr_t   wb_waddr;
    bwen_t    wb_bwen;
    logic     wb_vm;
    maddr_t   wb_mask_idx;
    logic     wb_mask_we;
    logic     wb_mask_bit;
    logic     vrf_we;
    vaddr_t   vrf_waddr;
    bwen_t    vrf_bwen;
    word_t    vrf_wdata;

    //////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////
    vector_regfile u_vrf (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .raddr_a_i (raddr_a_i),
        .raddr_b_i (raddr_b_i),
        .we_i      (vrf_we),
        .waddr_i   (vrf_waddr),
        .bwen_i    (vrf_bwen),
        .wdata_i   (vrf_wdata),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b)
    );

    //////////////////////////////////////////////////
    // Operand path and control delay, side by side
    //////////////////////////////////////////////////
    element_extract u_extract (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rdata_a_i  (rdata_a),
        .rdata_b_i  (rdata_b),
        .el_idx_a_i (ext_idx_a),
        .el_idx_b_i (ext_idx_b),
        .sew_i      (ext_sew),
        .opa_o      (opa),
        .opb_o      (opb)
    );

    op_ctrl_pipe u_ctrl (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .op_valid_i  (op_valid_i),
        .load_i      (load_i),
        .el_idx_a_i  (el_idx_a_i),
        .el_idx_b_i  (el_idx_b_i),
        .sew_i       (sew_i),
        .alu_op_i    (alu_op_i),
        .op2_src_i   (op2_src_i),
        .scalar_i    (scalar_i),
        .imm_i       (imm_i),
        .waddr_i     (waddr_i),
        .bwen_i      (bwen_i),
        .load_data_i (load_data_i),
        .vm_i        (vm_i),
        .mask_idx_i  (mask_idx_i),
        .mask_we_i   (mask_we_i),
        .el_idx_a_o  (ext_idx_a),
        .el_idx_b_o  (ext_idx_b),
        .sew_o       (ext_sew),
        .valid_o     (ex_valid),
        .load_o      (ex_load),
        .alu_op_o    (ex_alu_op),
        .op2_src_o   (ex_op2_src),
        .scalar_o    (ex_scalar),
        .imm_o       (ex_imm),
        .waddr_o     (ex_waddr),
        .bwen_o      (ex_bwen),
        .load_data_o (ex_load_data),
        .vm_o        (ex_vm),
        .mask_idx_o  (ex_mask_idx),
        .mask_we_o   (ex_mask_we)
    );

    //////////////////////////////////////////////////
    // Execute and write-back
    //////////////////////////////////////////////////
    execute_stage u_exec (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .opa_i          (opa),
        .opb_i          (opb),
        .valid_i        (ex_valid),
        .load_i         (ex_load),
        .alu_op_i       (ex_alu_op),
        .op2_src_i      (ex_op2_src),
        .scalar_i       (ex_scalar),
        .imm_i          (ex_imm),
        .waddr_i        (ex_waddr),
        .bwen_i         (ex_bwen),
        .load_data_i    (ex_load_data),
        .vm_i           (ex_vm),
        .mask_idx_i     (ex_mask_idx),
        .mask_we_i      (ex_mask_we),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .wb_we_o        (wb_we),
        .wb_data_o      (wb_data),
        .wb_waddr_o     (wb_waddr),
        .wb_bwen_o      (wb_bwen),
        .wb_vm_o        (wb_vm),
        .wb_mask_idx_o  (wb_mask_idx),
        .wb_mask_we_o   (wb_mask_we),
        .wb_mask_bit_o  (wb_mask_bit)
    );

    writeback_stage u_wb (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .wb_we_i       (wb_we),
        .wb_data_i     (wb_data),
        .wb_waddr_i    (wb_waddr),
        .wb_bwen_i     (wb_bwen),
        .wb_vm_i       (wb_vm),
        .wb_mask_idx_i (wb_mask_idx),
        .wb_mask_we_i  (wb_mask_we),
        .wb_mask_bit_i (wb_mask_bit),
        .vrf_we_o      (vrf_we),
        .vrf_waddr_o   (vrf_waddr),
        .vrf_bwen_o    (vrf_bwen),
        .vrf_wdata_o   (vrf_wdata)
    );

endmodule

/* src/writeback_stage.sv */
module writeback_stage (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             wb_we_i,
    input  lane_pkg::word_t  wb_data_i,
    input  lane_pkg::vaddr_t wb_waddr_i,
    input  lane_pkg::bwen_t  wb_bwen_i,
    input  logic             wb_vm_i,
    input  lane_pkg::maddr_t wb_mask_idx_i,
    input  logic             wb_mask_we_i,
    input  logic             wb_mask_bit_i,
    output logic             vrf_we_o,
    output lane_pkg::vaddr_t vrf_waddr_o,
    output lane_pkg::bwen_t  vrf_bwen_o,
    output lane_pkg::word_t  vrf_wdata_o
);
    import lane_pkg::*;

    logic [MASK_DEPTH-1:0] mask_q;
    logic                  mask_bit;
    logic                  masked_off;

    //////////////////////////////////////////////////
    // Mask register file
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            mask_q <= '0;
        end else if (wb_mask_we_i) begin
            mask_q[wb_mask_idx_i] <= wb_mask_bit_i;
        end
    end

    // Stored bit, a same-edge mask write is not seen yet
    assign mask_bit   = mask_q[wb_mask_idx_i];
    assign masked_off = wb_vm_i & ~mask_bit;

    //////////////////////////////////////////////////
    // Register file write
    //////////////////////////////////////////////////
    assign vrf_we_o    = wb_we_i;
    assign vrf_waddr_o = wb_waddr_i;
    assign vrf_wdata_o = wb_data_i;
    assign vrf_bwen_o  = masked_off ? '0 : (wb_bwen_i & {$bits(bwen_t){wb_we_i}});

endmodule

/* src/execute_stage.sv */
module execute_stage (
    input  logic               clk_i,
    input  logic               rst_i,
    input  lane_pkg::word_t    opa_i,
    input  lane_pkg::word_t    opb_i,
    input  logic               valid_i,
    input  logic               load_i,
    input  lane_pkg::alu_op_t  alu_op_i,
    input  lane_pkg::op2_src_t op2_src_i,
    input  lane_pkg::word_t    scalar_i,
    input  lane_pkg::imm_t     imm_i,
    input  lane_pkg::vaddr_t   waddr_i,
    input  lane_pkg::bwen_t    bwen_i,
    input  lane_pkg::word_t    load_data_i,
    input  logic               vm_i,
    input  lane_pkg::maddr_t   mask_idx_i,
    input  logic               mask_we_i,
    output lane_pkg::word_t    result_o,
    output logic               result_valid_o,
    output logic               wb_we_o,
    output lane_pkg::word_t    wb_data_o,
    output lane_pkg::vaddr_t   wb_waddr_o,
    output lane_pkg::bwen_t    wb_bwen_o,
    output logic               wb_vm_o,
    output lane_pkg::maddr_t   wb_mask_idx_o,
    output logic               wb_mask_we_o,
    output logic               wb_mask_bit_o
);
    import lane_pkg::*;

    word_t op2;
    word_t alu_res;

    //////////////////////////////////////////////////
    // Second operand select
    //////////////////////////////////////////////////
    always_comb begin
        case (op2_src_i)
            OP2_VREG:   op2 = opb_i;
            OP2_SCALAR: op2 = scalar_i;
            OP2_IMM:    op2 = word_t'(imm_i);
            default:    op2 = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////
    always_comb begin
        case (alu_op_i)
            OP_ADD:   alu_res = opa_i + op2;
            OP_SUB:   alu_res = opa_i - op2;
            OP_AND:   alu_res = opa_i & op2;
            OP_OR:    alu_res = opa_i | op2;
            OP_XOR:   alu_res = opa_i ^ op2;
            OP_SLL:   alu_res = opa_i << op2[4:0];
            OP_SRL:   alu_res = opa_i >> op2[4:0];
            OP_MSEQ:  alu_res = word_t'(opa_i == op2);
            OP_MSLTU: alu_res = word_t'(opa_i < op2);
            default:  alu_res = '0;
        endcase
    end

    // Strobes
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            result_valid_o <= 1'b0;
            wb_we_o        <= 1'b0;
            wb_mask_we_o   <= 1'b0;
        end else begin
            result_valid_o <= valid_i;
            wb_we_o        <= valid_i | load_i;
            wb_mask_we_o   <= valid_i & mask_we_i;
        end
    end

    // Result and write-back fields
    always_ff @(posedge clk_i) begin
        result_o      <= alu_res;
        wb_data_o     <= load_i ? load_data_i : alu_res;
        wb_waddr_o    <= waddr_i;
        wb_bwen_o     <= bwen_i;
        wb_vm_o       <= vm_i;
        wb_mask_idx_o <= mask_idx_i;
        // Compare outcome sits in bit 0
        wb_mask_bit_o <= alu_res[0];
    end

endmodule

/* src/op_ctrl_pipe.sv */
module op_ctrl_pipe (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               op_valid_i,
    input  logic               load_i,
    input  lane_pkg::el_idx_t  el_idx_a_i,
    input  lane_pkg::el_idx_t  el_idx_b_i,
    input  lane_pkg::sew_t     sew_i,
    input  lane_pkg::alu_op_t  alu_op_i,
    input  lane_pkg::op2_src_t op2_src_i,
    input  lane_pkg::word_t    scalar_i,
    input  lane_pkg::imm_t     imm_i,
    input  lane_pkg::vaddr_t   waddr_i,
    input  lane_pkg::bwen_t    bwen_i,
    input  lane_pkg::word_t    load_data_i,
    input  logic               vm_i,
    input  lane_pkg::maddr_t   mask_idx_i,
    input  logic               mask_we_i,
    output lane_pkg::el_idx_t  el_idx_a_o,
    output lane_pkg::el_idx_t  el_idx_b_o,
    output lane_pkg::sew_t     sew_o,
    output logic               valid_o,
    output logic               load_o,
    output lane_pkg::alu_op_t  alu_op_o,
    output lane_pkg::op2_src_t op2_src_o,
    output lane_pkg::word_t    scalar_o,
    output lane_pkg::imm_t     imm_o,
    output lane_pkg::vaddr_t   waddr_o,
    output lane_pkg::bwen_t    bwen_o,
    output lane_pkg::word_t    load_data_o,
    output logic               vm_o,
    output lane_pkg::maddr_t   mask_idx_o,
    output logic               mask_we_o
);
    import lane_pkg::*;

    localparam int LAST = EXTRACT_DELAY - 1;

    logic     [EXTRACT_DELAY-1:0] valid_q;
    logic     [EXTRACT_DELAY-1:0] load_q;
    logic     [EXTRACT_DELAY-1:0] vm_q;
    logic     [EXTRACT_DELAY-1:0] mask_we_q;
    alu_op_t  alu_op_q    [EXTRACT_DELAY];
    op2_src_t op2_src_q   [EXTRACT_DELAY];
    word_t    scalar_q    [EXTRACT_DELAY];
    imm_t     imm_q       [EXTRACT_DELAY];
    vaddr_t   waddr_q     [EXTRACT_DELAY];
    bwen_t    bwen_q      [EXTRACT_DELAY];
    word_t    load_data_q [EXTRACT_DELAY];
    maddr_t   mask_idx_q  [EXTRACT_DELAY];

    //////////////////////////////////////////////////
    // Strobes, the only state cleared on reset
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_q <= '0;
            load_q  <= '0;
        end else begin
            valid_q <= {valid_q[LAST-1:0], op_valid_i};
            load_q  <= {load_q[LAST-1:0], load_i};
        end
    end

    //////////////////////////////////////////////////
    // Element select, one stage for the extractor
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        el_idx_a_o <= el_idx_a_i;
        el_idx_b_o <= el_idx_b_i;
        sew_o      <= sew_i;
    end

    // Operation and write-back fields
    always_ff @(posedge clk_i) begin
        vm_q      <= {vm_q[LAST-1:0], vm_i};
        mask_we_q <= {mask_we_q[LAST-1:0], mask_we_i};
        alu_op_q[0]    <= alu_op_i;
        op2_src_q[0]   <= op2_src_i;
        scalar_q[0]    <= scalar_i;
        imm_q[0]       <= imm_i;
        waddr_q[0]     <= waddr_i;
        bwen_q[0]      <= bwen_i;
        load_data_q[0] <= load_data_i;
        mask_idx_q[0]  <= mask_idx_i;
        for (int i = 1; i < EXTRACT_DELAY; i++) begin
            alu_op_q[i]    <= alu_op_q[i-1];
            op2_src_q[i]   <= op2_src_q[i-1];
            scalar_q[i]    <= scalar_q[i-1];
            imm_q[i]       <= imm_q[i-1];
            waddr_q[i]     <= waddr_q[i-1];
            bwen_q[i]      <= bwen_q[i-1];
            load_data_q[i] <= load_data_q[i-1];
            mask_idx_q[i]  <= mask_idx_q[i-1];
        end
    end

    assign valid_o     = valid_q[LAST];
    assign load_o      = load_q[LAST];
    assign vm_o        = vm_q[LAST];
    assign mask_we_o   = mask_we_q[LAST];
    assign alu_op_o    = alu_op_q[LAST];
    assign op2_src_o   = op2_src_q[LAST];
    assign scalar_o    = scalar_q[LAST];
    assign imm_o       = imm_q[LAST];
    assign waddr_o     = waddr_q[LAST];
    assign bwen_o      = bwen_q[LAST];
    assign load_data_o = load_data_q[LAST];
    assign mask_idx_o  = mask_idx_q[LAST];

endmodule

/* src/element_extract.sv */
module element_extract (
    input  logic              clk_i,
    input  logic              rst_i,
    input  lane_pkg::word_t   rdata_a_i,
    input  lane_pkg::word_t   rdata_b_i,
    input  lane_pkg::el_idx_t el_idx_a_i,
    input  lane_pkg::el_idx_t el_idx_b_i,
    input  lane_pkg::sew_t    sew_i,
    output lane_pkg::word_t   opa_o,
    output lane_pkg::word_t   opb_o
);
    import lane_pkg::*;

    // Zero-extended element of one read word
    function automatic word_t extract_el(word_t w, el_idx_t idx, sew_t sew);
        word_t el;
        el = '0;
        case (sew)
            SEW_8:   el[7:0]  = w[{idx, 3'b000} +: 8];
            SEW_16:  el[15:0] = w[{idx[0], 4'b0000} +: 16];
            SEW_32:  el       = w;
            default: el       = '0;
        endcase
        return el;
    endfunction

    word_t opa_next;
    word_t opb_next;

    assign opa_next = extract_el(rdata_a_i, el_idx_a_i, sew_i);
    assign opb_next = extract_el(rdata_b_i, el_idx_b_i, sew_i);

    // Operand registers
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            opa_o <= '0;
            opb_o <= '0;
        end else begin
            opa_o <= opa_next;
            opb_o <= opb_next;
        end
    end

endmodule

/* src/vector_regfile.sv */
module vector_regfile (
    input  logic             clk_i,
    input  logic             rst_i,
    input  lane_pkg::vaddr_t raddr_a_i,
    input  lane_pkg::vaddr_t raddr_b_i,
    input  logic             we_i,
    input  lane_pkg::vaddr_t waddr_i,
    input  lane_pkg::bwen_t  bwen_i,
    input  lane_pkg::word_t  wdata_i,
    output lane_pkg::word_t  rdata_a_o,
    output lane_pkg::word_t  rdata_b_o
);
    import lane_pkg::*;

    word_t mem [VRF_DEPTH];

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int i = 0; i < VRF_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            // Only enabled byte lanes change
            for (int b = 0; b < $bits(bwen_t); b++) begin
                if (we_i && bwen_i[b]) begin
                    mem[waddr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////
    // Old word on a same-edge write
    always_ff @(posedge clk_i) begin
        rdata_a_o <= mem[raddr_a_i];
        rdata_b_o <= mem[raddr_b_i];
    end

endmodule

/* src/lane_pkg.sv */
package lane_pkg;

    //////////////////////////////////////////////////
    // Sizes and latencies
    //////////////////////////////////////////////////
    localparam int VRF_DEPTH  = 64;
    localparam int MASK_DEPTH = 32;

    // Issue to registered operands
    localparam int EXTRACT_DELAY = 2;
    // Issue to registered result
    localparam int LANE_LATENCY  = 3;

    //////////////////////////////////////////////////
    // Vector types
    //////////////////////////////////////////////////
    typedef logic [31:0]                     word_t;
    typedef logic [$clog2(VRF_DEPTH)-1:0]    vaddr_t;
    typedef logic [$clog2(MASK_DEPTH)-1:0]   maddr_t;
    typedef logic [3:0]                      bwen_t;
    typedef logic [1:0]                      el_idx_t;
    typedef logic [1:0]                      sew_t;
    typedef logic [4:0]                      imm_t;

    // Element widths, value 3 is reserved
    localparam sew_t SEW_8  = 2'd0;
    localparam sew_t SEW_16 = 2'd1;
    localparam sew_t SEW_32 = 2'd2;

    //////////////////////////////////////////////////
    // Operation encodings
    //////////////////////////////////////////////////
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_MSEQ,
        OP_MSLTU
    } alu_op_t;

    // Second operand source
    typedef enum logic [1:0] {
        OP2_VREG,
        OP2_SCALAR,
        OP2_IMM
    } op2_src_t;

endpackage
